// ==== build.f ====
+incdir+include
hw/radio_pkg.sv
hw/radio_settings.sv
hw/timekeeper.sv
hw/gpio_atr.sv
hw/radio_frontend.sv
hw/radio_core.sv
testbench/radio_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the radio core testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f build.f --top-module radio_core_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vradio_core_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi
exit 0

// ==== testbench/radio_core_tb.sv ====
//////////////////////////////
// Testbench for the radio control core:
// readback, timekeeper, TX pattern,
// loopback and ATR GPIO
//////////////////////////////

`timescale 1ns/1ps

`include "radio_consts.svh"

module radio_core_tb import radio_pkg::*; ();

   localparam int DRIVE_DELAY    = 2;
   localparam int TIMEOUT_CYCLES = 2000;   // Far beyond the length of all tests
   localparam logic [`SAMPLE_W-1:0] PATTERN_PAIR = {`TX_PATTERN_WORD, `TX_PATTERN_WORD};

   logic                   bus_clk;
   logic                   i_reset;
   logic                   i_set_stb;
   logic [`SET_ADDR_W-1:0] i_set_addr;
   logic [`SET_DATA_W-1:0] i_set_data;
   logic [`SAMPLE_W-1:0]   i_rx;
   logic                   i_run_rx;
   logic                   i_run_tx;
   logic [`GPIO_W-1:0]     i_fe_gpio_in;
   logic                   i_pps;
   logic [`SAMPLE_W-1:0]   o_tx;
   logic [`SAMPLE_W-1:0]   o_rx_sample;
   logic [`GPIO_W-1:0]     o_fe_gpio_out;
   logic [`GPIO_W-1:0]     o_fe_gpio_ddr;
   logic [`TIME_W-1:0]     o_vita_time;
   logic [`TIME_W-1:0]     o_rb_data;

   integer               seed;
   int                   cycle_cnt = 0;
   logic [`SAMPLE_W-1:0] tx_idle_val;
   logic                 tx_check_en;
   logic                 tx_locked    = 1'b0;
   logic                 tx_last_zero = 1'b0;
   logic [1:0]           tx_phase     = 2'd0;  // Phase of the last o_tx seen

   radio_core u_dut (.*);

   initial begin
      bus_clk = 1'b0;
      forever #20 bus_clk = ~bus_clk;
   end

   //////////////////////////////
   // Reference model

   function automatic logic [`TIME_W-1:0] ref_readback(rb_sel_t sel,
         logic [31:0] test_val, logic [63:0] time_now, logic [63:0] time_pps,
         logic [31:0] tx, logic [31:0] rx, logic [31:0] gpio_in);
      case (sel)
         RB_TEST:       return {32'd0, test_val};
         RB_TIME_NOW:   return time_now;
         RB_TIME_PPS:   return time_pps;
         RB_FE_SAMPLES: return {tx, rx};
         RB_GPIO_IN:    return {32'd0, gpio_in};
         default:       return '0;
      endcase
   endfunction

   function automatic logic [`SAMPLE_W-1:0] ref_tx_word(logic run_tx, logic [1:0] phase,
         logic [`SAMPLE_W-1:0] idle);
      if (!run_tx)
         return idle;
      return phase[1] ? PATTERN_PAIR : '0;  // Two cycles zero, two cycles pattern
   endfunction

   function automatic logic [`GPIO_W-1:0] ref_atr_out(atr_state_t st,
         logic [3:0][`GPIO_W-1:0] vals);
      case (st)
         ATR_IDLE: return vals[0];
         ATR_RX:   return vals[1];
         ATR_TX:   return vals[2];
         default:  return vals[3];          // Full duplex
      endcase
   endfunction

   //////////////////////////////
   // Compare tasks

   task automatic stop_with_failure();
      $display("SIMULATION FAILED");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_rb(input logic [`TIME_W-1:0] got, input logic [`TIME_W-1:0] exp);
      if (got !== exp) begin
         $display("FAILED: o_rb_data got %h expected %h", got, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_time(input logic [`TIME_W-1:0] got, input logic [`TIME_W-1:0] exp);
      if (got !== exp) begin
         $display("FAILED: o_vita_time got %h expected %h", got, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_sample(input string name, input logic [`SAMPLE_W-1:0] got,
         input logic [`SAMPLE_W-1:0] exp);
      if (got !== exp) begin
         $display("FAILED: %s got %h expected %h", name, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_gpio(input string name, input atr_state_t st,
         input logic [`GPIO_W-1:0] got, input logic [`GPIO_W-1:0] exp);
      if (got !== exp) begin
         $display("FAILED: %s in %s got %h expected %h", name, st.name(), got, exp);
         stop_with_failure();
      end
   endtask

   task automatic step_cycle();
      @(posedge bus_clk);
      #DRIVE_DELAY;
   endtask

   task automatic write_setting(input logic [`SET_ADDR_W-1:0] addr,
         input logic [`SET_DATA_W-1:0] data);
      i_set_stb  = 1'b1;
      i_set_addr = addr;
      i_set_data = data;
      step_cycle();
      i_set_stb  = 1'b0;
   endtask

   // TX pattern checker that locks on the first zero to pattern step
   always @(negedge bus_clk) begin
      if (tx_check_en) begin
         if (tx_locked) begin
            tx_phase = tx_phase + 2'd1;
            check_sample("o_tx", o_tx, ref_tx_word(1'b1, tx_phase, tx_idle_val));
         end else if (o_tx == PATTERN_PAIR && tx_last_zero) begin
            tx_locked = 1'b1;
            tx_phase  = 2'd2;                // First of two pattern cycles
         end else if (o_tx != PATTERN_PAIR) begin
            check_sample("o_tx", o_tx, '0);
         end
         tx_last_zero = (o_tx == '0);
      end
   end

   always @(posedge bus_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         stop_with_failure();
      end
   end

   //////////////////////////////
   // Stimulus

   initial begin
      logic [`SET_DATA_W-1:0]  hi;
      logic [`SET_DATA_W-1:0]  lo;
      logic [`SET_DATA_W-1:0]  val;
      logic [`SAMPLE_W-1:0]    rx_val;
      logic [`GPIO_W-1:0]      gpio_in_val;
      logic [`GPIO_W-1:0]      ddr_val;
      logic [3:0][`GPIO_W-1:0] atr_vals;
      logic [`TIME_W-1:0]      exp_time;
      logic [`TIME_W-1:0]      pps_time;
      atr_state_t              st;

      seed         = 32'h93c3;
      i_reset      = 1'b1;
      i_set_stb    = 1'b0;
      i_set_addr   = '0;
      i_set_data   = '0;
      i_rx         = '0;
      i_run_rx     = 1'b0;
      i_run_tx     = 1'b0;
      i_fe_gpio_in = '0;
      i_pps        = 1'b0;
      tx_check_en  = 1'b0;
      tx_idle_val  = '0;
      repeat (10) @(posedge bus_clk);
      #DRIVE_DELAY;
      i_reset = 1'b0;

      // Reset values, test register, reserved slots
      check_gpio("o_fe_gpio_ddr", ATR_IDLE, o_fe_gpio_ddr, `GPIO_DEFAULT_DDR);
      check_gpio("o_fe_gpio_out", ATR_IDLE, o_fe_gpio_out, `GPIO_DEFAULT_IDLE);
      check_sample("o_tx", o_tx, '0);
      write_setting(`SR_READBACK, {29'd0, RB_TEST});
      repeat (4) begin
         val = $random(seed);
         write_setting(`SR_TEST, val);
         step_cycle();
         check_rb(o_rb_data, ref_readback(RB_TEST, val, '0, '0, '0, '0, '0));
      end
      for (int k = 5; k < 8; k++) begin
         write_setting(`SR_READBACK, k);
         step_cycle();
         check_rb(o_rb_data, ref_readback(rb_sel_t'(k[2:0]), val, '0, '0, '0, '0, '0));
      end

      // Load now
      hi = $random(seed);
      lo = $random(seed);
      write_setting(`SR_TIME, hi);
      write_setting(`SR_TIME + 8'd1, lo);
      write_setting(`SR_TIME + 8'd2, 32'd1);
      exp_time = {hi, lo};
      check_time(o_vita_time, exp_time);
      repeat (20) begin
         step_cycle();
         exp_time = exp_time + 64'd1;
         check_time(o_vita_time, exp_time);
      end

      // Readback of the running time lags one cycle
      write_setting(`SR_READBACK, {29'd0, RB_TIME_NOW});
      exp_time = exp_time + 64'd1;
      step_cycle();
      check_rb(o_rb_data, ref_readback(RB_TIME_NOW, '0, exp_time, '0, '0, '0, '0));
      exp_time = exp_time + 64'd1;

      // Load on PPS, then latch on a second edge
      hi = $random(seed);
      lo = $random(seed);
      write_setting(`SR_TIME, hi);
      write_setting(`SR_TIME + 8'd1, lo);
      write_setting(`SR_TIME + 8'd2, 32'd0);
      exp_time = exp_time + 64'd3;
      repeat (5) begin
         step_cycle();
         exp_time = exp_time + 64'd1;
         check_time(o_vita_time, exp_time);
      end
      i_pps = 1'b1;
      step_cycle();
      exp_time = {hi, lo};
      check_time(o_vita_time, exp_time);
      i_pps = 1'b0;
      repeat (3) step_cycle();
      exp_time = exp_time + 64'd3;
      pps_time = exp_time;                  // Time in the edge cycle
      i_pps    = 1'b1;
      step_cycle();
      exp_time = exp_time + 64'd1;
      check_time(o_vita_time, exp_time);
      i_pps = 1'b0;
      write_setting(`SR_READBACK, {29'd0, RB_TIME_PPS});
      step_cycle();
      check_rb(o_rb_data, ref_readback(RB_TIME_PPS, '0, '0, pps_time, '0, '0, '0));

      // Idle word, then the running pattern
      tx_idle_val = $random(seed);
      write_setting(`SR_CODEC_IDLE, tx_idle_val);
      step_cycle();
      check_sample("o_tx", o_tx, ref_tx_word(1'b0, 2'd0, tx_idle_val));
      i_run_tx = 1'b1;
      step_cycle();
      tx_check_en = 1'b1;
      repeat (16) step_cycle();

      // Loopback off, then on while the pattern runs
      rx_val = $random(seed);
      i_rx   = rx_val;
      step_cycle();
      check_sample("o_rx_sample", o_rx_sample, rx_val);
      write_setting(`SR_LOOPBACK, 32'd1);
      repeat (8) begin
         step_cycle();
         check_sample("o_rx_sample", o_rx_sample, ref_tx_word(1'b1, tx_phase, tx_idle_val));
      end
      tx_check_en = 1'b0;
      i_run_tx    = 1'b0;
      write_setting(`SR_LOOPBACK, 32'd0);
      step_cycle();
      check_sample("o_tx", o_tx, ref_tx_word(1'b0, 2'd0, tx_idle_val));
      check_sample("o_rx_sample", o_rx_sample, rx_val);
      write_setting(`SR_READBACK, {29'd0, RB_FE_SAMPLES});
      step_cycle();
      check_rb(o_rb_data, ref_readback(RB_FE_SAMPLES, '0, '0, '0, tx_idle_val, rx_val, '0));

      // ATR outputs for every run state
      for (int k = 0; k < 4; k++) begin
         atr_vals[k] = $random(seed);
         write_setting(`SR_ATR + k[7:0], atr_vals[k]);
      end
      ddr_val = $random(seed);
      write_setting(`SR_ATR + 8'd4, ddr_val);
      gpio_in_val  = $random(seed);
      i_fe_gpio_in = gpio_in_val;
      for (int s = 0; s < 4; s++) begin
         i_run_rx = s[0];
         i_run_tx = s[1];
         st = (i_run_rx && i_run_tx) ? ATR_FDX : i_run_tx ? ATR_TX : i_run_rx ? ATR_RX : ATR_IDLE;
         step_cycle();
         check_gpio("o_fe_gpio_out", st, o_fe_gpio_out, ref_atr_out(st, atr_vals));
         check_gpio("o_fe_gpio_ddr", st, o_fe_gpio_ddr, ddr_val);
      end
      write_setting(`SR_READBACK, {29'd0, RB_GPIO_IN});
      step_cycle();
      check_rb(o_rb_data, ref_readback(RB_GPIO_IN, '0, '0, '0, '0, '0, gpio_in_val));

      if (tx_locked) begin
         $display("SIMULATION PASSED");
         $finish;
      end else begin
         $display("No start of a TX pattern pair was seen on o_tx");
         stop_with_failure();
      end
   end

endmodule

// ==== hw/radio_core.sv ====
//////////////////////////////
// Radio control core top level: settings,
// timekeeper, ATR GPIO and TX/RX frontend
//////////////////////////////

`timescale 1ns/1ps

`include "radio_consts.svh"

module radio_core (
   input  logic                   bus_clk,
   input  logic                   i_reset,
   // Settings bus
   input  logic                   i_set_stb,
   input  logic [`SET_ADDR_W-1:0] i_set_addr,
   input  logic [`SET_DATA_W-1:0] i_set_data,
   // Codec samples and run levels
   input  logic [`SAMPLE_W-1:0]   i_rx,
   input  logic                   i_run_rx,
   input  logic                   i_run_tx,
   input  logic [`GPIO_W-1:0]     i_fe_gpio_in,
   input  logic                   i_pps,
   output logic [`SAMPLE_W-1:0]   o_tx,
   output logic [`SAMPLE_W-1:0]   o_rx_sample,
   output logic [`GPIO_W-1:0]     o_fe_gpio_out,
   output logic [`GPIO_W-1:0]     o_fe_gpio_ddr,
   output logic [`TIME_W-1:0]     o_vita_time,
   output logic [`TIME_W-1:0]     o_rb_data
);

   logic [`TIME_W-1:0]   vita_time_pps;
   logic                 loopback;
   logic [`SAMPLE_W-1:0] tx_idle;

   radio_settings u_settings (
      .bus_clk         (bus_clk),
      .i_reset         (i_reset),
      .i_set_stb       (i_set_stb),
      .i_set_addr      (i_set_addr),
      .i_set_data      (i_set_data),
      .i_vita_time     (o_vita_time),
      .i_vita_time_pps (vita_time_pps),
      .i_tx            (o_tx),
      .i_rx_sample     (o_rx_sample),
      .i_gpio_in       (i_fe_gpio_in),
      .o_loopback      (loopback),
      .o_tx_idle       (tx_idle),
      .o_rb_data       (o_rb_data)
   );

   timekeeper u_timekeeper (
      .bus_clk         (bus_clk),
      .i_reset         (i_reset),
      .i_set_stb       (i_set_stb),
      .i_set_addr      (i_set_addr),
      .i_set_data      (i_set_data),
      .i_pps           (i_pps),
      .o_vita_time     (o_vita_time),
      .o_vita_time_pps (vita_time_pps)
   );

   // Front-end pins follow the run state
   gpio_atr u_fe_gpio_atr (
      .bus_clk    (bus_clk),
      .i_reset    (i_reset),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .i_run_rx   (i_run_rx),
      .i_run_tx   (i_run_tx),
      .o_gpio_out (o_fe_gpio_out),
      .o_gpio_ddr (o_fe_gpio_ddr)
   );

   radio_frontend u_frontend (
      .bus_clk     (bus_clk),
      .i_reset     (i_reset),
      .i_run_tx    (i_run_tx),
      .i_tx_idle   (tx_idle),
      .i_loopback  (loopback),
      .i_rx        (i_rx),
      .o_tx        (o_tx),
      .o_rx_sample (o_rx_sample)
   );

endmodule

// ==== hw/radio_frontend.sv ====
//////////////////////////////
// TX test pattern or codec idle word,
// RX capture with digital loopback
//////////////////////////////

`timescale 1ns/1ps

`include "radio_consts.svh"

module radio_frontend (
   input  logic                 bus_clk,
   input  logic                 i_reset,
   input  logic                 i_run_tx,
   input  logic [`SAMPLE_W-1:0] i_tx_idle,
   input  logic                 i_loopback,
   input  logic [`SAMPLE_W-1:0] i_rx,
   output logic [`SAMPLE_W-1:0] o_tx,
   output logic [`SAMPLE_W-1:0] o_rx_sample
);

   logic [1:0] phase_cnt;       // Bit 1 sets the pattern half

   //////////////////////////////
   // TX side

   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         phase_cnt <= 2'd0;
         o_tx      <= '0;
      end else begin
         phase_cnt <= phase_cnt + 2'd1;
         if (!i_run_tx)
            o_tx <= i_tx_idle;                                  // Codec sits at idle word
         else if (phase_cnt[1])
            o_tx <= {`TX_PATTERN_WORD, `TX_PATTERN_WORD};       // Same word on I and Q
         else
            o_tx <= '0;
      end
   end

   //////////////////////////////
   // RX side

   // Loopback takes the registered TX word, so it lags o_tx by one cycle
   always_ff @(posedge bus_clk) begin
      if (i_reset)
         o_rx_sample <= '0;
      else
         o_rx_sample <= i_loopback ? o_tx : i_rx;
   end

endmodule

// ==== hw/gpio_atr.sv ====
//////////////////////////////
// ATR GPIO registers and output select
// by the TX/RX run state
//////////////////////////////

`timescale 1ns/1ps

`include "radio_consts.svh"

module gpio_atr import radio_pkg::*; (
   input  logic                   bus_clk,
   input  logic                   i_reset,
   input  logic                   i_set_stb,
   input  logic [`SET_ADDR_W-1:0] i_set_addr,
   input  logic [`SET_DATA_W-1:0] i_set_data,
   input  logic                   i_run_rx,
   input  logic                   i_run_tx,
   output logic [`GPIO_W-1:0]     o_gpio_out,
   output logic [`GPIO_W-1:0]     o_gpio_ddr
);

   logic [`GPIO_W-1:0] out_idle;
   logic [`GPIO_W-1:0] out_rx;
   logic [`GPIO_W-1:0] out_tx;
   logic [`GPIO_W-1:0] out_fdx;
   atr_state_t         atr_state;

   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         out_idle   <= `GPIO_DEFAULT_IDLE;
         out_rx     <= '0;
         out_tx     <= '0;
         out_fdx    <= '0;
         o_gpio_ddr <= `GPIO_DEFAULT_DDR;
      end else if (i_set_stb) begin
         case (i_set_addr)
            `SR_ATR:         out_idle   <= i_set_data[`GPIO_W-1:0];
            `SR_ATR + 8'd1:  out_rx     <= i_set_data[`GPIO_W-1:0];
            `SR_ATR + 8'd2:  out_tx     <= i_set_data[`GPIO_W-1:0];
            `SR_ATR + 8'd3:  out_fdx    <= i_set_data[`GPIO_W-1:0];
            `SR_ATR + 8'd4:  o_gpio_ddr <= i_set_data[`GPIO_W-1:0]; // 1 = output
            default: ;
         endcase
      end
   end

   assign atr_state = atr_state_t'({i_run_tx, i_run_rx});

   //////////////////////////////
   // Output select

   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         o_gpio_out <= `GPIO_DEFAULT_IDLE;
      end else begin
         case (atr_state)
            ATR_IDLE: o_gpio_out <= out_idle;
            ATR_RX:   o_gpio_out <= out_rx;
            ATR_TX:   o_gpio_out <= out_tx;
            default:  o_gpio_out <= out_fdx;                 // Full duplex
         endcase
      end
   end

   gpio_ddr_default: assert property (
      @(posedge bus_clk) i_reset |=> (o_gpio_ddr == `GPIO_DEFAULT_DDR)
   );

endmodule

// ==== hw/timekeeper.sv ====
//////////////////////////////
// VITA time counter with load now or load
// on next PPS, and PPS time latch
//////////////////////////////

`timescale 1ns/1ps

`include "radio_consts.svh"

module timekeeper import radio_pkg::*; (
   input  logic                   bus_clk,
   input  logic                   i_reset,
   input  logic                   i_set_stb,
   input  logic [`SET_ADDR_W-1:0] i_set_addr,
   input  logic [`SET_DATA_W-1:0] i_set_data,
   input  logic                   i_pps,
   output logic [`TIME_W-1:0]     o_vita_time,
   output logic [`TIME_W-1:0]     o_vita_time_pps
);

   logic [`SET_DATA_W-1:0] time_hi;
   logic [`SET_DATA_W-1:0] time_lo;
   logic                   pps_d;
   logic                   pps_edge;
   logic                   ctrl_wr;
   logic                   load_now;
   tk_state_t              tk_state;

   // Staging registers applied by a CTRL write
   always_ff @(posedge bus_clk) begin
      if (i_set_stb && (i_set_addr == `SR_TIME))
         time_hi <= i_set_data;
      if (i_set_stb && (i_set_addr == `SR_TIME + 8'd1))
         time_lo <= i_set_data;
   end

   assign ctrl_wr  = i_set_stb && (i_set_addr == `SR_TIME + 8'd2);
   assign load_now = ctrl_wr && i_set_data[0];
   assign pps_edge = i_pps && !pps_d;

   //////////////////////////////
   // Counter and load FSM

   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         pps_d           <= 1'b0;
         tk_state        <= TK_IDLE;
         o_vita_time     <= '0;
         o_vita_time_pps <= '0;
      end else begin
         pps_d <= i_pps;
         if (pps_edge)
            o_vita_time_pps <= o_vita_time;                  // Time of this edge cycle
         if (load_now) begin
            tk_state    <= TK_IDLE;
            o_vita_time <= {time_hi, time_lo};
         end else if (ctrl_wr) begin
            tk_state    <= TK_ARMED;                         // Wait for next PPS
            o_vita_time <= o_vita_time + `TIME_W'(1);
         end else if ((tk_state == TK_ARMED) && pps_edge) begin
            tk_state    <= TK_IDLE;
            o_vita_time <= {time_hi, time_lo};
         end else begin
            o_vita_time <= o_vita_time + `TIME_W'(1);
         end
      end
   end

   // Armed load is only cancelled by PPS, reset or a load-now write
   tk_armed_hold: assert property (
      @(posedge bus_clk)
      (tk_state == TK_ARMED && !pps_edge && !load_now && !i_reset) |=> (tk_state == TK_ARMED)
   );

endmodule

// ==== hw/radio_settings.sv ====
//////////////////////////////
// Loopback, test, codec idle and readback
// select registers, registered readback mux
//////////////////////////////

`timescale 1ns/1ps

`include "radio_consts.svh"

module radio_settings import radio_pkg::*; (
   input  logic                   bus_clk,
   input  logic                   i_reset,
   input  logic                   i_set_stb,
   input  logic [`SET_ADDR_W-1:0] i_set_addr,
   input  logic [`SET_DATA_W-1:0] i_set_data,
   input  logic [`TIME_W-1:0]     i_vita_time,
   input  logic [`TIME_W-1:0]     i_vita_time_pps,
   input  logic [`SAMPLE_W-1:0]   i_tx,
   input  logic [`SAMPLE_W-1:0]   i_rx_sample,
   input  logic [`GPIO_W-1:0]     i_gpio_in,
   output logic                   o_loopback,
   output logic [`SAMPLE_W-1:0]   o_tx_idle,
   output logic [`TIME_W-1:0]     o_rb_data
);

   logic [`SET_DATA_W-1:0] test_reg;
   rb_sel_t                rb_sel;

   //////////////////////////////
   // Setting registers

   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         o_loopback <= 1'b0;
         test_reg   <= '0;
         o_tx_idle  <= '0;
         rb_sel     <= RB_TEST;
      end else if (i_set_stb) begin
         case (i_set_addr)
            `SR_LOOPBACK:   o_loopback <= i_set_data[0];     // TX looped into RX
            `SR_TEST:       test_reg   <= i_set_data;
            `SR_CODEC_IDLE: o_tx_idle  <= i_set_data[`SAMPLE_W-1:0];
            `SR_READBACK:   rb_sel     <= rb_sel_t'(i_set_data[2:0]);
            default: ;                                       // Other blocks' addresses
         endcase
      end
   end

   //////////////////////////////
   // Readback mux

   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         o_rb_data <= '0;
      end else begin
         case (rb_sel)
            RB_TEST:       o_rb_data <= {{(`TIME_W-`SET_DATA_W){1'b0}}, test_reg};
            RB_TIME_NOW:   o_rb_data <= i_vita_time;
            RB_TIME_PPS:   o_rb_data <= i_vita_time_pps;
            RB_FE_SAMPLES: o_rb_data <= {i_tx, i_rx_sample};
            RB_GPIO_IN:    o_rb_data <= {{(`TIME_W-`GPIO_W){1'b0}}, i_gpio_in};
            default:       o_rb_data <= '0;                  // Slots 5 to 7 unused
         endcase
      end
   end

   // A reserved slot never leaks stale data
   rb_rsvd_zero: assert property (
      @(posedge bus_clk) disable iff (i_reset)
      (rb_sel inside {RB_RSVD5, RB_RSVD6, RB_RSVD7}) |=> (o_rb_data == '0)
   );

endmodule

// ==== hw/radio_pkg.sv ====
//////////////////////////////
// Shared types of the radio core:
// readback select, ATR state, timekeeper state
//////////////////////////////

package radio_pkg;

   // Readback slots, written through SR_READBACK
   typedef enum logic [2:0] {
      RB_TEST       = 3'd0,
      RB_TIME_NOW   = 3'd1,
      RB_TIME_PPS   = 3'd2,
      RB_FE_SAMPLES = 3'd3,
      RB_GPIO_IN    = 3'd4,
      RB_RSVD5      = 3'd5,
      RB_RSVD6      = 3'd6,
      RB_RSVD7      = 3'd7
   } rb_sel_t;

   // Encoded as {run_tx, run_rx}
   typedef enum logic [1:0] {
      ATR_IDLE = 2'd0,
      ATR_RX   = 2'd1,
      ATR_TX   = 2'd2,
      ATR_FDX  = 2'd3
   } atr_state_t;

   typedef enum logic {
      TK_IDLE  = 1'b0,
      TK_ARMED = 1'b1      // Waiting for a PPS edge to load time
   } tk_state_t;

endpackage

// ==== include/radio_consts.svh ====
//////////////////////////////
// Setting bus addresses, bus and data widths,
// TX test pattern word and ATR reset defaults
//////////////////////////////

`ifndef RADIO_CONSTS_SVH
`define RADIO_CONSTS_SVH

//////////////////////////////
// Setting addresses

`define SR_LOOPBACK   8'd6
`define SR_ATR        8'd12   // Five registers, idle/rx/tx/fdx/ddr
`define SR_TEST       8'd21
`define SR_CODEC_IDLE 8'd22
`define SR_READBACK   8'd32
`define SR_TIME       8'd128  // HI, LO, then CTRL

//////////////////////////////
// Widths

`define SET_ADDR_W 8
`define SET_DATA_W 32
`define TIME_W     64
`define SAMPLE_W   32         // I in the upper half, Q in the lower
`define GPIO_W     32

//////////////////////////////
// Data words and defaults

// Half-word sent on I and Q while the pattern is high
`define TX_PATTERN_WORD 16'hAAAA

// Front-end ATR pins are always outputs
`define GPIO_DEFAULT_DDR  32'hFFFF_FFFF
`define GPIO_DEFAULT_IDLE 32'h0000_0000

`endif
